/* design/eth_stats_pkg.sv */
// one 8-byte beat per cycle with byte 0 in the msb; counts are 16 bits and saturate
`default_nettype none

package eth_stats_pkg;

	// data path
	typedef logic [63:0] beat_t;

	localparam int BEAT_BYTES = 8;
	localparam int EMPTY_W    = 3;
	localparam int CNT_W_DEF  = 13;

	// header byte offsets from the first byte of the destination address
	localparam int DA_OFS        = 0;
	localparam int TYPE_OFS      = 12;
	localparam int OPCODE_OFS    = 14;
	localparam int VLAN_TYPE_OFS = 16;
	localparam int SVLAN_LEN_OFS = 20;
	localparam int HDR_BYTES     = 24;

	localparam logic [15:0] ETYPE_VLAN   = 16'h8100;
	localparam logic [15:0] ETYPE_CTRL   = 16'h8808;
	localparam logic [15:0] OPCODE_PAUSE = 16'h0001;
	localparam logic [15:0] OPCODE_PFC   = 16'h0101;

	// length rules
	localparam int CRC_BYTES       = 4;
	localparam int BASE_HDR_BYTES  = 14;
	localparam int VLAN_TAG_BYTES  = 4;
	localparam int SVLAN_TAG_BYTES = 8;
	localparam int MIN_FRAME_BYTES = 64;
	localparam int MAX_LEN_FIELD   = 1500;

	typedef struct packed {
		logic        ucast;
		logic        mcast;
		logic        bcast;
		logic        vlan;
		logic        svlan;
		logic        ctrl;
		logic        pause;
		logic        pfc;
		logic [15:0] len_field;
	} frm_class_t;

	typedef struct packed {
		logic [15:0] frame_bcnt;
		logic [15:0] data_bcnt;
	} frm_len_t;

	localparam int STATS_W = 40;
	localparam int ERR_W   = 3;

endpackage

`default_nettype wire

/* design/align_pipe.sv */
// DEPTH must be at least 1; every stage clears to zero on reset
`timescale 1ns/10ps
`default_nettype none

module align_pipe #(
	parameter type T     = logic,
	parameter int  DEPTH = 1
) (
	input  wire  clk,
	input  wire  rst_n_i,
	input  var T d_i,
	output T     q_o
);

	T stage_q [DEPTH];

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < DEPTH; i++)
				stage_q[i] <= '0;
		end else begin
			stage_q[0] <= d_i;
			for (int i = 1; i < DEPTH; i++)
				stage_q[i] <= stage_q[i-1];
		end
	end

	assign q_o = stage_q[DEPTH-1];

endmodule

`default_nettype wire

/* design/eth_hdr_classify.sv */
// decodes only the first 24 header bytes; bytes a short frame never carried read as zero
`timescale 1ns/10ps
`default_nettype none

module eth_hdr_classify
	import eth_stats_pkg::*;
(
	input  wire        clk,
	input  wire        rst_n_i,
	input  wire beat_t frm_data_i,
	input  wire        frm_sop_i,
	input  wire        frm_eop_i,
	input  wire        frm_valid_i,
	output frm_class_t hdr_o,
	output logic       hdr_done_o
);

	localparam int HDR_W  = HDR_BYTES * 8;
	localparam int BEAT_W = BEAT_BYTES * 8;

	logic [HDR_W-1:0] hdr_q;
	logic [HDR_W-1:0] hdr_cur;
	logic [1:0]       beat_idx;
	logic [1:0]       cur_idx;
	logic [47:0]      da;
	logic [15:0]      etype;
	logic [15:0]      inner_type;
	logic [15:0]      opcode;
	logic             vlan_type;
	frm_class_t       hdr_nxt;

	function automatic logic [15:0] field16(input logic [HDR_W-1:0] hdr, input int ofs);
		return hdr[HDR_W - 1 - ofs * 8 -: 16];
	endfunction

	// ------------------------------------------------------------------
	// header capture, beats 0 to 2
	// ------------------------------------------------------------------
	assign cur_idx = frm_sop_i ? 2'd0 : beat_idx;

	always_comb begin
		hdr_cur = frm_sop_i ? '0 : hdr_q;
		// the eop beat itself joins the decode
		if (cur_idx != 2'd3)
			hdr_cur[HDR_W - 1 - BEAT_W * cur_idx -: BEAT_W] = frm_data_i;
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			hdr_q    <= '0;
			beat_idx <= '0;
		end else if (frm_valid_i) begin
			hdr_q <= hdr_cur;
			// stop at 3, later beats carry no header
			if (cur_idx != 2'd3)
				beat_idx <= cur_idx + 2'd1;
			else
				beat_idx <= cur_idx;
		end
	end

	// ------------------------------------------------------------------
	// class decode
	// ------------------------------------------------------------------
	assign da         = hdr_cur[HDR_W - 1 - DA_OFS * 8 -: 48];
	assign etype      = field16(hdr_cur, TYPE_OFS);
	assign inner_type = field16(hdr_cur, VLAN_TYPE_OFS);
	assign opcode     = field16(hdr_cur, OPCODE_OFS);
	assign vlan_type  = (etype == ETYPE_VLAN);

	always_comb begin
		// group bit is bit 0 of the first address byte
		hdr_nxt.bcast = &da;
		hdr_nxt.mcast = da[40] & ~(&da);
		hdr_nxt.ucast = ~da[40];
		hdr_nxt.svlan = vlan_type & (inner_type == ETYPE_VLAN);
		hdr_nxt.vlan  = vlan_type & (inner_type != ETYPE_VLAN);
		hdr_nxt.ctrl  = (etype == ETYPE_CTRL);
		hdr_nxt.pause = hdr_nxt.ctrl & (opcode == OPCODE_PAUSE);
		hdr_nxt.pfc   = hdr_nxt.ctrl & (opcode == OPCODE_PFC);
		if (hdr_nxt.svlan)
			hdr_nxt.len_field = field16(hdr_cur, SVLAN_LEN_OFS);
		else if (hdr_nxt.vlan)
			hdr_nxt.len_field = inner_type;
		else
			hdr_nxt.len_field = etype;
	end

	always_ff @(posedge clk) begin
		if (frm_valid_i && frm_eop_i)
			hdr_o <= hdr_nxt;
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i)
			hdr_done_o <= 1'b0;
		else
			hdr_done_o <= frm_valid_i & frm_eop_i;
	end

endmodule

`default_nettype wire

/* design/eth_len_count.sv */
// CNT_W up to 28; beat count saturates, frame count saturates at FFFFh
`timescale 1ns/10ps
`default_nettype none

module eth_len_count
	import eth_stats_pkg::*;
#(
	parameter int CNT_W = CNT_W_DEF
) (
	input  wire               clk,
	input  wire               rst_n_i,
	input  wire               frm_sop_i,
	input  wire               frm_eop_i,
	input  wire [EMPTY_W-1:0] frm_empty_i,
	input  wire               frm_valid_i,
	input  wire               cfg_crc_included_i,
	output frm_len_t          len_o,
	output logic              len_done_o
);

	logic [CNT_W-1:0] beat_cnt;
	logic [CNT_W-1:0] beat_nxt;
	logic [31:0]      rx_bytes;
	logic [31:0]      frame_wide;
	logic [15:0]      frame_sat;
	logic [15:0]      data_nxt;

	// beats so far including the current one
	always_comb begin
		if (frm_sop_i)
			beat_nxt = CNT_W'(1);
		else if (&beat_cnt)
			beat_nxt = beat_cnt;
		else
			beat_nxt = beat_cnt + CNT_W'(1);
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i)
			beat_cnt <= '0;
		else if (frm_valid_i)
			beat_cnt <= beat_nxt;
	end

	// ------------------------------------------------------------------
	// byte counts on the eop beat
	// ------------------------------------------------------------------
	assign rx_bytes   = 32'(beat_nxt) * BEAT_BYTES - 32'(frm_empty_i);
	assign frame_wide = cfg_crc_included_i ? rx_bytes : rx_bytes + CRC_BYTES;
	assign frame_sat  = (frame_wide > 32'hFFFF) ? 16'hFFFF : frame_wide[15:0];

	// tag bytes stay in, the classifier owns the tag class
	assign data_nxt = (frame_sat > 16'(CRC_BYTES + BASE_HDR_BYTES)) ?
		frame_sat - 16'(CRC_BYTES + BASE_HDR_BYTES) : 16'd0;

	always_ff @(posedge clk) begin
		if (frm_valid_i && frm_eop_i) begin
			len_o.frame_bcnt <= frame_sat;
			len_o.data_bcnt  <= data_nxt;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i)
			len_done_o <= 1'b0;
		else
			len_done_o <= frm_valid_i & frm_eop_i;
	end

endmodule

`default_nettype wire

/* design/eth_stats_merge.sv */
// hdr_i, len_i and the config inputs must hold for one cycle after done_i
`timescale 1ns/10ps
`default_nettype none

module eth_stats_merge
	import eth_stats_pkg::*;
(
	input  wire               clk,
	input  wire               rst_n_i,
	input  wire frm_class_t   hdr_i,
	input  wire frm_len_t     len_i,
	input  wire               done_i,
	input  wire [15:0]        cfg_max_frm_length_i,
	input  wire               cfg_vlandet_disable_i,
	output logic [STATS_W-1:0] stats_o,
	output logic              stats_valid_o,
	output logic [ERR_W-1:0]  frm_error_o
);

	frm_class_t       hdr_s1;
	bit               done_s1;
	logic [15:0]      tag_bytes;
	logic [15:0]      meas_bytes;
	logic [15:0]      pld_nxt;
	logic             tag_ignored;
	logic [ERR_W-1:0] err_nxt;
	logic [15:0]      pld_s1;
	logic [15:0]      frame_s1;
	logic [ERR_W-1:0] err_s1;

	// class and done flag ride alongside stage 1
	align_pipe #(.T(frm_class_t), .DEPTH(1)) hdr_pipe_inst (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.d_i     (hdr_i),
		.q_o     (hdr_s1)
	);

	align_pipe #(.T(bit), .DEPTH(1)) done_pipe_inst (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.d_i     (done_i),
		.q_o     (done_s1)
	);

	// ------------------------------------------------------------------
	// stage 1, payload count and checks
	// ------------------------------------------------------------------
	always_comb begin
		if (hdr_i.svlan)
			tag_bytes = 16'(SVLAN_TAG_BYTES);
		else if (hdr_i.vlan)
			tag_bytes = 16'(VLAN_TAG_BYTES);
		else
			tag_bytes = 16'd0;
		meas_bytes = (len_i.data_bcnt > tag_bytes) ? len_i.data_bcnt - tag_bytes : 16'd0;
		pld_nxt = cfg_vlandet_disable_i ? meas_bytes + tag_bytes : meas_bytes;
		// no length check on control frames or tags passed through as data
		tag_ignored = cfg_vlandet_disable_i & (hdr_i.vlan | hdr_i.svlan);
		err_nxt[0] = len_i.frame_bcnt < 16'(MIN_FRAME_BYTES);
		err_nxt[1] = len_i.frame_bcnt > cfg_max_frm_length_i;
		err_nxt[2] = (hdr_i.len_field <= 16'(MAX_LEN_FIELD)) &
			(hdr_i.len_field > meas_bytes) & ~hdr_i.ctrl & ~tag_ignored;
	end

	always_ff @(posedge clk) begin
		pld_s1   <= pld_nxt;
		frame_s1 <= len_i.frame_bcnt;
		err_s1   <= err_nxt;
	end

	// ------------------------------------------------------------------
	// stage 2, stats vector
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (done_s1) begin
			stats_o <= {hdr_s1.pfc, hdr_s1.ucast, hdr_s1.mcast, hdr_s1.bcast,
				hdr_s1.pause, hdr_s1.ctrl, hdr_s1.vlan, hdr_s1.svlan, frame_s1, pld_s1};
			frm_error_o <= err_s1;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i)
			stats_valid_o <= 1'b0;
		else
			stats_valid_o <= done_s1;
	end

endmodule

`default_nettype wire

/* design/eth_rx_stats.sv */
// no back-pressure; stats_valid_o pulses three clock edges after the eop beat is taken
`timescale 1ns/10ps
`default_nettype none

module eth_rx_stats
	import eth_stats_pkg::*;
#(
	parameter int CNT_W = CNT_W_DEF
) (
	input  wire                clk,
	input  wire                rst_n_i,
	input  wire beat_t         frm_data_i,
	input  wire                frm_sop_i,
	input  wire                frm_eop_i,
	input  wire [EMPTY_W-1:0]  frm_empty_i,
	input  wire                frm_valid_i,
	input  wire                cfg_crc_included_i,
	input  wire [15:0]         cfg_max_frm_length_i,
	input  wire                cfg_vlandet_disable_i,
	output logic [STATS_W-1:0] stats_o,
	output logic               stats_valid_o,
	output logic [ERR_W-1:0]   frm_error_o
);

	frm_class_t hdr_res;
	frm_len_t   len_res;
	logic       len_done;

	// classifier and counter see the same beats
	eth_hdr_classify hdr_classify_inst (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.frm_data_i  (frm_data_i),
		.frm_sop_i   (frm_sop_i),
		.frm_eop_i   (frm_eop_i),
		.frm_valid_i (frm_valid_i),
		.hdr_o       (hdr_res),
		.hdr_done_o  ()
	);

	eth_len_count #(.CNT_W(CNT_W)) len_count_inst (
		.clk                (clk),
		.rst_n_i            (rst_n_i),
		.frm_sop_i          (frm_sop_i),
		.frm_eop_i          (frm_eop_i),
		.frm_empty_i        (frm_empty_i),
		.frm_valid_i        (frm_valid_i),
		.cfg_crc_included_i (cfg_crc_included_i),
		.len_o              (len_res),
		.len_done_o         (len_done)
	);

	// both done flags match, one is enough
	eth_stats_merge stats_merge_inst (
		.clk                   (clk),
		.rst_n_i               (rst_n_i),
		.hdr_i                 (hdr_res),
		.len_i                 (len_res),
		.done_i                (len_done),
		.cfg_max_frm_length_i  (cfg_max_frm_length_i),
		.cfg_vlandet_disable_i (cfg_vlandet_disable_i),
		.stats_o               (stats_o),
		.stats_valid_o         (stats_valid_o),
		.frm_error_o           (frm_error_o)
	);

endmodule

`default_nettype wire

/* sim/eth_rx_stats_chk.sv */
// bound to eth_rx_stats; expects a fixed latency of three clock edges from eop to stats
`timescale 1ns/10ps
`default_nettype none

module eth_rx_stats_chk
	import eth_stats_pkg::*;
(
	input wire               clk,
	input wire               rst_n_i,
	input wire               frm_valid_i,
	input wire               frm_eop_i,
	input wire [STATS_W-1:0] stats_o,
	input wire               stats_valid_o
);

	int fail_cnt = 0;

	// ------------------------------------------------------------------
	// timing
	// ------------------------------------------------------------------
	latency_a: assert property (@(posedge clk) disable iff (!rst_n_i)
		stats_valid_o == $past(frm_valid_i && frm_eop_i, 3))
	else begin
		$error("stats pulse does not match an eop beat three edges earlier");
		fail_cnt++;
	end

	reset_a: assert property (@(posedge clk)
		(!rst_n_i || $rose(rst_n_i)) |-> !stats_valid_o)
	else begin
		$error("stats valid is high during or right after reset");
		fail_cnt++;
	end

	// ------------------------------------------------------------------
	// flag consistency
	// ------------------------------------------------------------------
	// ucast, mcast, bcast live in bits 38 to 36
	addr_class_a: assert property (@(posedge clk) disable iff (!rst_n_i)
		stats_valid_o |-> $onehot(stats_o[38:36]))
	else begin
		$error("address class flags are not one-hot");
		fail_cnt++;
	end

	tag_class_a: assert property (@(posedge clk) disable iff (!rst_n_i)
		stats_valid_o |-> !(stats_o[33] && stats_o[32]))
	else begin
		$error("vlan and stacked vlan flags are both set");
		fail_cnt++;
	end

	ctrl_a: assert property (@(posedge clk) disable iff (!rst_n_i)
		stats_valid_o |-> (!(stats_o[35] || stats_o[39]) || stats_o[34]))
	else begin
		$error("pause or pfc flag set without the control flag");
		fail_cnt++;
	end

endmodule

bind eth_rx_stats eth_rx_stats_chk chk_inst (
	.clk           (clk),
	.rst_n_i       (rst_n_i),
	.frm_valid_i   (frm_valid_i),
	.frm_eop_i     (frm_eop_i),
	.stats_o       (stats_o),
	.stats_valid_o (stats_valid_o)
);

`default_nettype wire

/* sim/eth_rx_stats_tb.sv */
// frames up to 256 bytes; config changes only after the merge stage has drained
`timescale 1ns/10ps
`default_nettype none

module eth_rx_stats_tb
	import eth_stats_pkg::*;
();

	localparam int CLK_PERIOD     = 100;
	localparam int NUM_FRAMES     = 40;
	localparam int MAX_FRM_CYCLES = 48;
	localparam int TIMEOUT_NS     = (NUM_FRAMES * MAX_FRM_CYCLES + 50) * CLK_PERIOD;

	localparam logic [47:0] BCAST_DA = 48'hffff_ffff_ffff;
	localparam logic [47:0] MCAST_DA = 48'h0100_5e00_0001;
	localparam logic [47:0] PAUSE_DA = 48'h0180_c200_0001;

	logic               clk;
	logic               rst_n;
	beat_t              data;
	logic               sop;
	logic               eop;
	logic [EMPTY_W-1:0] empty;
	logic               valid;
	logic               crc_inc;
	logic [15:0]        max_len;
	logic               vlandet_dis;
	logic [STATS_W-1:0] stats;
	logic               stats_valid;
	logic [ERR_W-1:0]   frm_err;

	logic [7:0]         frm_bytes [256];
	int                 frm_len;
	logic [STATS_W-1:0] exp_stats_q [$];
	logic [ERR_W-1:0]   exp_err_q [$];
	int                 err_cnt = 0;
	int                 sent_cnt = 0;
	int                 chk_cnt = 0;

	eth_rx_stats #(.CNT_W(CNT_W_DEF)) eth_rx_stats_inst (
		.clk                   (clk),
		.rst_n_i               (rst_n),
		.frm_data_i            (data),
		.frm_sop_i             (sop),
		.frm_eop_i             (eop),
		.frm_empty_i           (empty),
		.frm_valid_i           (valid),
		.cfg_crc_included_i    (crc_inc),
		.cfg_max_frm_length_i  (max_len),
		.cfg_vlandet_disable_i (vlandet_dis),
		.stats_o               (stats),
		.stats_valid_o         (stats_valid),
		.frm_error_o           (frm_err)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ------------------------------------------------------------------
	// reference model of one frame, header bytes past the end read as zero
	// ------------------------------------------------------------------
	function automatic void expect_frame();
		logic [7:0]       h [HDR_BYTES];
		logic [47:0]      da;
		logic [15:0]      etype, inner, opcode, len_fld;
		logic             uc, mc, bc, vl, sv, ct, pa, pf;
		int               frame_b, data_b, tag_b, meas_b, pld_b;
		logic [ERR_W-1:0] e;
		for (int i = 0; i < HDR_BYTES; i++)
			h[i] = (i < frm_len) ? frm_bytes[i] : 8'h00;
		da = {h[0], h[1], h[2], h[3], h[4], h[5]};
		etype = {h[12], h[13]};
		opcode = {h[14], h[15]};
		inner = {h[16], h[17]};
		bc = (da == BCAST_DA);
		uc = ~h[0][0];
		mc = h[0][0] & ~bc;
		sv = (etype == ETYPE_VLAN) && (inner == ETYPE_VLAN);
		vl = (etype == ETYPE_VLAN) && !sv;
		ct = (etype == ETYPE_CTRL);
		pa = ct && (opcode == OPCODE_PAUSE);
		pf = ct && (opcode == OPCODE_PFC);
		len_fld = sv ? {h[20], h[21]} : (vl ? inner : etype);
		frame_b = frm_len + (crc_inc ? 0 : CRC_BYTES);
		if (frame_b > 65535)
			frame_b = 65535;
		data_b = frame_b - CRC_BYTES - BASE_HDR_BYTES;
		if (data_b < 0)
			data_b = 0;
		tag_b = sv ? SVLAN_TAG_BYTES : (vl ? VLAN_TAG_BYTES : 0);
		meas_b = (data_b > tag_b) ? data_b - tag_b : 0;
		pld_b = vlandet_dis ? meas_b + tag_b : meas_b;
		e[0] = (frame_b < MIN_FRAME_BYTES);
		e[1] = (frame_b > int'(max_len));
		e[2] = (int'(len_fld) <= MAX_LEN_FIELD) && (int'(len_fld) > meas_b) && !ct &&
			!(vlandet_dis && (vl || sv));
		// flags from bit 39 down to bit 32
		exp_stats_q.push_back({pf, uc, mc, bc, pa, ct, vl, sv, 16'(frame_b), 16'(pld_b)});
		exp_err_q.push_back(e);
	endfunction

	function automatic logic [47:0] rand_ucast();
		logic [47:0] d;
		d = {16'($urandom()), $urandom()};
		d[40] = 1'b0;
		return d;
	endfunction

	function automatic int rand_len();
		return 64 + int'($urandom() % 137);
	endfunction

	// ------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------
	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			#1;
			valid = 1'b0;
			sop = 1'b0;
			eop = 1'b0;
		end
	endtask

	task automatic set_cfg(input logic crc, input logic [15:0] maxl, input logic vdis);
		// frames in flight clear the merge stage first
		idle(4);
		crc_inc = crc;
		max_len = maxl;
		vlandet_dis = vdis;
	endtask

	// tags is 0, 1 or 2; fld lands after the tags and op right behind it
	task automatic send_frame(input logic [47:0] da, input int tags, input logic [15:0] fld,
			input logic [15:0] op, input int nbytes, input int gap);
		int    nbeats;
		int    pos;
		beat_t beat;
		for (int i = 0; i < 256; i++)
			frm_bytes[i] = 8'($urandom());
		for (int i = 0; i < 6; i++)
			frm_bytes[i] = da[47 - 8 * i -: 8];
		pos = TYPE_OFS;
		for (int t = 0; t < tags; t++) begin
			{frm_bytes[pos], frm_bytes[pos + 1]} = ETYPE_VLAN;
			pos += VLAN_TAG_BYTES;
		end
		{frm_bytes[pos], frm_bytes[pos + 1]} = fld;
		{frm_bytes[pos + 2], frm_bytes[pos + 3]} = op;
		frm_len = nbytes;
		expect_frame();
		nbeats = (nbytes + BEAT_BYTES - 1) / BEAT_BYTES;
		for (int b = 0; b < nbeats; b++) begin
			for (int k = 0; k < BEAT_BYTES; k++)
				beat[63 - 8 * k -: 8] = (b * 8 + k < nbytes) ? frm_bytes[b * 8 + k] : 8'h00;
			@(posedge clk);
			#1;
			data = beat;
			sop = (b == 0);
			eop = (b == nbeats - 1);
			valid = 1'b1;
			empty = (b == nbeats - 1) ? EMPTY_W'(nbeats * BEAT_BYTES - nbytes) : '0;
		end
		sent_cnt++;
		idle(gap);
	endtask

	// ------------------------------------------------------------------
	// checking
	// ------------------------------------------------------------------
	task automatic compare_field(input string name, input logic [39:0] exp_v,
			input logic [39:0] act_v);
		assert (act_v === exp_v) else begin
			$display("** Error @%0t ns: %s expected %0h, got %0h", $time, name, exp_v, act_v);
			err_cnt++;
		end
	endtask

	task automatic check_stats();
		logic [STATS_W-1:0] exp_s;
		logic [ERR_W-1:0]   exp_e;
		if (exp_stats_q.size() == 0) begin
			$display("stats pulse at %0t ns with no frame outstanding", $time);
			err_cnt++;
		end else begin
			exp_s = exp_stats_q.pop_front();
			exp_e = exp_err_q.pop_front();
			compare_field("stats_o[15:0]", 40'(exp_s[15:0]), 40'(stats[15:0]));
			compare_field("stats_o[31:16]", 40'(exp_s[31:16]), 40'(stats[31:16]));
			compare_field("stats_o[39:32]", 40'(exp_s[39:32]), 40'(stats[39:32]));
			compare_field("frm_error_o", 40'(exp_e), 40'(frm_err));
			chk_cnt++;
		end
	endtask

	always @(negedge clk) begin
		if (rst_n && stats_valid)
			check_stats();
	end

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog expired with %0d frames still waiting for stats",
			exp_stats_q.size());
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		int kind;
		int gap;
		void'($urandom(6856));
		clk = 1'b0;
		rst_n = 1'b0;
		data = '0;
		sop = 1'b0;
		eop = 1'b0;
		empty = '0;
		valid = 1'b0;
		crc_inc = 1'b1;
		max_len = 16'd1518;
		vlandet_dis = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// untagged unicast, with and without crc
		set_cfg(1'b1, 16'd1518, 1'b0);
		repeat (4) send_frame(rand_ucast(), 0, 16'h0800, 16'h0000, rand_len(), 1);
		send_frame(rand_ucast(), 0, 16'd82, 16'h0000, 100, 1);
		set_cfg(1'b0, 16'd1518, 1'b0);
		repeat (2) send_frame(rand_ucast(), 0, 16'h0800, 16'h0000, rand_len(), 2);

		// address and tag classes
		set_cfg(1'b1, 16'd1518, 1'b0);
		send_frame(BCAST_DA, 0, 16'h0806, 16'h0000, rand_len(), 1);
		send_frame(MCAST_DA, 0, 16'h0800, 16'h0000, rand_len(), 1);
		send_frame(rand_ucast(), 1, 16'h0800, 16'h0000, rand_len(), 1);
		send_frame(rand_ucast(), 2, 16'h0800, 16'h0000, rand_len(), 1);
		set_cfg(1'b1, 16'd1518, 1'b1);
		send_frame(MCAST_DA, 1, 16'h0800, 16'h0000, rand_len(), 1);
		// length field above the measured data, tags passed through as data
		send_frame(rand_ucast(), 2, 16'd600, 16'h0000, rand_len(), 1);

		// control frames
		set_cfg(1'b1, 16'd1518, 1'b0);
		send_frame(PAUSE_DA, 0, ETYPE_CTRL, OPCODE_PAUSE, 64, 1);
		send_frame(PAUSE_DA, 0, ETYPE_CTRL, OPCODE_PFC, 64, 1);

		// size limits
		send_frame(rand_ucast(), 0, 16'h0800, 16'h0000, 60, 1);
		send_frame(rand_ucast(), 0, 16'h0800, 16'h0000, 20, 1);
		set_cfg(1'b1, 16'd100, 1'b0);
		send_frame(rand_ucast(), 0, 16'h0800, 16'h0000, 128, 1);

		// length field against measured payload
		set_cfg(1'b1, 16'd1518, 1'b0);
		send_frame(rand_ucast(), 0, 16'd100, 16'h0000, 80, 1);
		send_frame(rand_ucast(), 0, 16'd1501, 16'h0000, 80, 1);
		send_frame(rand_ucast(), 0, 16'd1500, 16'h0000, 80, 1);
		send_frame(rand_ucast(), 1, 16'd60, 16'h0000, 80, 1);

		// back to back, single beats included
		send_frame(rand_ucast(), 0, 16'h0800, 16'h0000, 8, 0);
		send_frame(BCAST_DA, 0, 16'h0800, 16'h0000, 3, 0);
		send_frame(rand_ucast(), 1, 16'h0800, 16'h0000, rand_len(), 0);
		send_frame(MCAST_DA, 0, 16'h0800, 16'h0000, 5, 0);
		send_frame(rand_ucast(), 0, 16'd46, 16'h0000, 64, 0);
		send_frame(PAUSE_DA, 0, ETYPE_CTRL, OPCODE_PFC, 64, 0);
		send_frame(rand_ucast(), 0, 16'h0800, 16'h0000, 1, 0);
		send_frame(rand_ucast(), 2, 16'h0800, 16'h0000, rand_len(), 2);

		// random mix with random gaps
		set_cfg(1'b0, 16'd1518, 1'b1);
		for (int n = 0; n < 8; n++) begin
			kind = int'($urandom() % 5);
			gap = int'($urandom() % 4);
			case (kind)
				0: send_frame(rand_ucast(), 0, 16'h0800, 16'h0000, rand_len(), gap);
				1: send_frame(BCAST_DA, 0, 16'h86dd, 16'h0000, rand_len(), gap);
				2: send_frame(MCAST_DA, 1, 16'h0800, 16'h0000, rand_len(), gap);
				3: send_frame(rand_ucast(), 2, 16'd40, 16'h0000, rand_len(), gap);
				default: send_frame(PAUSE_DA, 0, ETYPE_CTRL, OPCODE_PAUSE, 64, gap);
			endcase
		end

		idle(1);
		while (exp_stats_q.size() != 0)
			@(posedge clk);
		idle(4);
		$display("frames sent %0d, checked %0d, value errors %0d, assertion failures %0d",
			sent_cnt, chk_cnt, err_cnt, eth_rx_stats_inst.chk_inst.fail_cnt);
		if (err_cnt == 0 && eth_rx_stats_inst.chk_inst.fail_cnt == 0 && chk_cnt == sent_cnt)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

/* eth_rx_stats.f */
design/eth_stats_pkg.sv
design/align_pipe.sv
design/eth_hdr_classify.sv
design/eth_len_count.sv
design/eth_stats_merge.sv
design/eth_rx_stats.sv
sim/eth_rx_stats_chk.sv
sim/eth_rx_stats_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
set -e

cd "$(dirname "$0")"
rm -rf obj_dir

verilator --binary --timing --assert -j 0 \
	--top-module eth_rx_stats_tb \
	-f eth_rx_stats.f

if ./obj_dir/Veth_rx_stats_tb | tee /dev/stderr | grep -x '=== PASS ===' > /dev/null; then
	exit 0
fi
exit 1
